/* verilog/cop_defines.svh */
// Coprocessor feature enables and custom major opcode
`ifndef COP_DEFINES_SVH
`define COP_DEFINES_SVH

// Custom-0 major opcode used by every coprocessor instruction
`define COP_OPCODE 7'b0001011

// Instruction class enables
`define COP_EN_PACKED    1
`define COP_EN_MOVE      1
`define COP_EN_TWIDDLE   0
`define COP_EN_LOADSTORE 0
`define COP_EN_RANDOM    0
`define COP_EN_MP        0
`define COP_EN_BITWISE   0

// Pack width enables
// 32-bit lanes are always available
`define COP_EN_P16 1
`define COP_EN_P8  1
`define COP_EN_P4  1
`define COP_EN_P2  1

`endif

/* verilog/cop_pkg.sv */
// Coprocessor package with data widths, class, subclass and pack width codes
package cop_pkg;

    // Widths with a meaning
    typedef logic [31:0] word_t;    // Data word
    typedef logic [3:0]  cr_idx_t;  // CPR index
    typedef logic [4:0]  gpr_idx_t; // GPR index
    typedef logic [2:0]  iclass_t;  // Instruction class
    typedef logic [3:0]  subclass_t;
    typedef logic [2:0]  pw_t;      // Pack width code

    // Instruction classes, code 0 is illegal
    localparam iclass_t ICLASS_PACKED_ARITH = 3'd1;
    localparam iclass_t ICLASS_TWIDDLE      = 3'd2;
    localparam iclass_t ICLASS_LOADSTORE    = 3'd3;
    localparam iclass_t ICLASS_RANDOM       = 3'd4;
    localparam iclass_t ICLASS_MOVE         = 3'd5;
    localparam iclass_t ICLASS_MP           = 3'd6;
    localparam iclass_t ICLASS_BITWISE      = 3'd7;

    // Packed arithmetic subclasses
    // Code 2 would be the packed multiply, not present here
    localparam subclass_t SCLASS_ADD_PX  = 4'd0;
    localparam subclass_t SCLASS_SUB_PX  = 4'd1;
    localparam subclass_t SCLASS_SLL_PX  = 4'd3;
    localparam subclass_t SCLASS_SRL_PX  = 4'd4;
    localparam subclass_t SCLASS_ROT_PX  = 4'd5;
    localparam subclass_t SCLASS_SLLI_PX = 4'd6;
    localparam subclass_t SCLASS_SRLI_PX = 4'd7;
    localparam subclass_t SCLASS_ROTI_PX = 4'd8;

    // Move subclasses
    localparam subclass_t SCLASS_MV2GPR = 4'd0; // CPR to GPR
    localparam subclass_t SCLASS_MV2COP = 4'd1; // GPR to CPR
    localparam subclass_t SCLASS_CMOV   = 4'd2; // Move if crs2 non-zero
    localparam subclass_t SCLASS_CMOVN  = 4'd3; // Move if crs2 zero

    // Pack width codes, lane width halves with each step
    localparam pw_t PW_32 = 3'd0;
    localparam pw_t PW_16 = 3'd1;
    localparam pw_t PW_8  = 3'd2;
    localparam pw_t PW_4  = 3'd3;
    localparam pw_t PW_2  = 3'd4;

endpackage

/* verilog/cop_idecode.sv */
// Coprocessor instruction decoder, fully combinational, with illegal instruction check
`timescale 1ns/1ns
`include "cop_defines.svh"

module cop_idecode (
    input  cop_pkg::word_t     instr,        // Encoded instruction
    output logic               id_exception, // Illegal instruction
    output cop_pkg::iclass_t   id_class,
    output cop_pkg::subclass_t id_subclass,
    output cop_pkg::pw_t       id_pw,        // Pack width code
    output cop_pkg::cr_idx_t   id_crs1,
    output cop_pkg::cr_idx_t   id_crs2,
    output cop_pkg::cr_idx_t   id_crd,
    output cop_pkg::gpr_idx_t  id_rd,        // GPR destination
    output cop_pkg::word_t     id_imm        // Zero-extended shift amount
);

    import cop_pkg::*;

    logic opcode_ok;
    logic class_ok;       // Class known and enabled
    logic is_packed;
    logic is_move;
    logic packed_sub_ok;
    logic pw_ok;          // Pack width legal and enabled
    logic move_sub_ok;

    // Fixed field layout
    assign id_class    = instr[31:29];
    assign id_subclass = instr[28:25];
    assign id_pw       = instr[14:12];
    assign id_rd       = instr[11:7];
    assign id_crd      = instr[10:7];   // Low bits of rd
    assign id_crs1     = instr[18:15];  // Low bits of rs1
    assign id_crs2     = instr[23:20];  // Shares bits with the shift amount
    assign id_imm      = {27'b0, instr[24:20]};

    assign opcode_ok = (instr[6:0] == `COP_OPCODE);

    assign is_packed = (id_class == ICLASS_PACKED_ARITH);
    assign is_move   = (id_class == ICLASS_MOVE);

    // Class check against the feature enables
    always_comb begin
        case (id_class)
            ICLASS_PACKED_ARITH: class_ok = (`COP_EN_PACKED != 0);
            ICLASS_TWIDDLE:      class_ok = (`COP_EN_TWIDDLE != 0);
            ICLASS_LOADSTORE:    class_ok = (`COP_EN_LOADSTORE != 0);
            ICLASS_RANDOM:       class_ok = (`COP_EN_RANDOM != 0);
            ICLASS_MOVE:         class_ok = (`COP_EN_MOVE != 0);
            ICLASS_MP:           class_ok = (`COP_EN_MP != 0);
            ICLASS_BITWISE:      class_ok = (`COP_EN_BITWISE != 0);
            default:             class_ok = 1'b0; // Class 0
        endcase
    end

    // Packed subclasses, multiply slot falls to default
    always_comb begin
        case (id_subclass)
            SCLASS_ADD_PX,
            SCLASS_SUB_PX,
            SCLASS_SLL_PX,
            SCLASS_SRL_PX,
            SCLASS_ROT_PX,
            SCLASS_SLLI_PX,
            SCLASS_SRLI_PX,
            SCLASS_ROTI_PX: packed_sub_ok = 1'b1;
            default:        packed_sub_ok = 1'b0;
        endcase
    end

    always_comb begin
        case (id_pw)
            PW_32:   pw_ok = 1'b1;
            PW_16:   pw_ok = (`COP_EN_P16 != 0);
            PW_8:    pw_ok = (`COP_EN_P8 != 0);
            PW_4:    pw_ok = (`COP_EN_P4 != 0);
            PW_2:    pw_ok = (`COP_EN_P2 != 0);
            default: pw_ok = 1'b0;
        endcase
    end

    // Four move instructions, codes 0 to 3
    assign move_sub_ok = (id_subclass <= SCLASS_CMOVN);

    assign id_exception = !opcode_ok ||
                          !class_ok  ||
                          (is_packed && (!packed_sub_ok || !pw_ok)) ||
                          (is_move && !move_sub_ok);

endmodule

/* verilog/cop_regfile.sv */
// Coprocessor register file, sixteen CPRs with two read ports and write-through
`timescale 1ns/1ns

module cop_regfile (
    input  logic             g_clk,
    input  logic             rst_n,
    input  cop_pkg::cr_idx_t ra_addr,
    input  cop_pkg::cr_idx_t rb_addr,
    output cop_pkg::word_t   ra_data,
    output cop_pkg::word_t   rb_data,
    input  logic             wen,
    input  cop_pkg::cr_idx_t waddr,
    input  cop_pkg::word_t   wdata
);

    import cop_pkg::*;

    word_t regs [0:15];
    logic  fwd_a;        // Port A hits the write
    logic  fwd_b;

    // All CPRs start at zero
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through lets a dependent instruction issue without a stall
    assign fwd_a = wen && (waddr == ra_addr);
    assign fwd_b = wen && (waddr == rb_addr);

    assign ra_data = fwd_a ? wdata : regs[ra_addr];
    assign rb_data = fwd_b ? wdata : regs[rb_addr];

endmodule

/* verilog/cop_palu.sv */
// Packed ALU with lane-wise add, subtract, shift and rotate at selectable widths
`timescale 1ns/1ns

module cop_palu (
    input  cop_pkg::subclass_t subclass,
    input  cop_pkg::pw_t       pw,
    input  cop_pkg::word_t     opa,
    input  cop_pkg::word_t     opb,
    input  cop_pkg::word_t     imm,     // Immediate shift amount
    output cop_pkg::word_t     result
);

    import cop_pkg::*;

    logic       use_imm;
    logic [4:0] shamt;        // Amount before the lane modulo
    word_t [4:0] pw_res;      // One result per lane width

    assign use_imm = (subclass == SCLASS_SLLI_PX) ||
                     (subclass == SCLASS_SRLI_PX) ||
                     (subclass == SCLASS_ROTI_PX);

    assign shamt = use_imm ? imm[4:0] : opb[4:0];

    // Lane width is 32 >> w, w being the pack width code
    for (genvar w = 0; w < 5; w++) begin : g_pw
        localparam int LW = 32 >> w;
        localparam int AW = $clog2(LW);

        for (genvar l = 0; l < 32 / LW; l++) begin : g_lane
            logic [LW-1:0]   la;
            logic [LW-1:0]   lb;
            logic [LW-1:0]   lr;
            logic [AW-1:0]   amt;     // Amount modulo lane width
            logic [2*LW-1:0] rot_w;

            assign la  = opa[l*LW +: LW];
            assign lb  = opb[l*LW +: LW];
            assign amt = shamt[AW-1:0];

            // Rotate right, low half of the doubled lane
            assign rot_w = {la, la} >> amt;

            always_comb begin
                case (subclass)
                    SCLASS_ADD_PX:                 lr = la + lb; // Wraps in lane
                    SCLASS_SUB_PX:                 lr = la - lb;
                    SCLASS_SLL_PX, SCLASS_SLLI_PX: lr = la << amt;
                    SCLASS_SRL_PX, SCLASS_SRLI_PX: lr = la >> amt;
                    SCLASS_ROT_PX, SCLASS_ROTI_PX: lr = rot_w[LW-1:0];
                    default:                       lr = '0;
                endcase
            end

            assign pw_res[w][l*LW +: LW] = lr;
        end
    end

    // Width select, illegal codes never reach writeback
    always_comb begin
        case (pw)
            PW_32:   result = pw_res[0];
            PW_16:   result = pw_res[1];
            PW_8:    result = pw_res[2];
            PW_4:    result = pw_res[3];
            PW_2:    result = pw_res[4];
            default: result = '0;
        endcase
    end

endmodule

/* verilog/cop_top.sv */
// Coprocessor top with decode, CPR read, packed and move execute, and writeback
`timescale 1ns/1ns

module cop_top (
    input  logic              g_clk,
    input  logic              rst_n,
    input  logic              instr_valid,   // One-cycle strobe
    input  cop_pkg::word_t    instr,
    input  cop_pkg::word_t    gpr_rs1_data,  // Valid with the strobe
    output logic              result_valid,
    output logic              exception,
    output logic              gpr_wen,
    output cop_pkg::gpr_idx_t gpr_rd,
    output cop_pkg::word_t    gpr_wdata
);

    import cop_pkg::*;

    // Decoder outputs
    logic      id_exception;
    iclass_t   id_class;
    subclass_t id_subclass;
    pw_t       id_pw;
    cr_idx_t   id_crs1;
    cr_idx_t   id_crs2;
    cr_idx_t   id_crd;
    gpr_idx_t  id_rd;
    word_t     id_imm;
    word_t     ra_data;
    word_t     rb_data;

    // Stage 1 registers
    logic      s1_valid;
    logic      s1_exc;
    iclass_t   s1_class;
    subclass_t s1_subclass;
    pw_t       s1_pw;
    cr_idx_t   s1_crd;
    gpr_idx_t  s1_rd;
    word_t     s1_imm;
    word_t     s1_opa;        // crs1 value
    word_t     s1_opb;        // crs2 value
    word_t     s1_gpr;

    // Execute
    logic      ex_ok;         // Valid and legal
    logic      is_packed;
    logic      is_move;
    logic      opb_zero;
    logic      cpr_wen;
    logic      gpr_wen_nxt;
    word_t     palu_result;
    word_t     move_result;
    word_t     ex_result;

    cop_idecode idecode_i (
        .instr        (instr),
        .id_exception (id_exception),
        .id_class     (id_class),
        .id_subclass  (id_subclass),
        .id_pw        (id_pw),
        .id_crs1      (id_crs1),
        .id_crs2      (id_crs2),
        .id_crd       (id_crd),
        .id_rd        (id_rd),
        .id_imm       (id_imm)
    );

    cop_regfile regfile_i (
        .g_clk   (g_clk),
        .rst_n   (rst_n),
        .ra_addr (id_crs1),
        .rb_addr (id_crs2),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .wen     (cpr_wen),
        .waddr   (s1_crd),
        .wdata   (ex_result)
    );

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1_exc   <= 1'b0;
        end else begin
            s1_valid <= instr_valid;
            s1_exc   <= instr_valid && id_exception;
        end
    end

    // Stage 1 payload
    always_ff @(posedge g_clk) begin
        if (instr_valid) begin
            s1_class    <= id_class;
            s1_subclass <= id_subclass;
            s1_pw       <= id_pw;
            s1_crd      <= id_crd;
            s1_rd       <= id_rd;
            s1_imm      <= id_imm;
            s1_opa      <= ra_data;
            s1_opb      <= rb_data;
            s1_gpr      <= gpr_rs1_data;
        end
    end

    cop_palu palu_i (
        .subclass (s1_subclass),
        .pw       (s1_pw),
        .opa      (s1_opa),
        .opb      (s1_opb),
        .imm      (s1_imm),
        .result   (palu_result)
    );

    assign ex_ok     = s1_valid && !s1_exc;
    assign is_packed = (s1_class == ICLASS_PACKED_ARITH);
    assign is_move   = (s1_class == ICLASS_MOVE);
    assign opb_zero  = (s1_opb == '0);

    // Only mv2cop takes the GPR, every other move carries crs1
    assign move_result = (s1_subclass == SCLASS_MV2COP) ? s1_gpr : s1_opa;
    assign ex_result   = is_packed ? palu_result : move_result;

    // Conditional moves skip the write when the test fails
    assign cpr_wen = ex_ok && (is_packed ||
                     (is_move && ((s1_subclass == SCLASS_MV2COP) ||
                                  (s1_subclass == SCLASS_CMOV && !opb_zero) ||
                                  (s1_subclass == SCLASS_CMOVN && opb_zero))));

    assign gpr_wen_nxt = ex_ok && is_move && (s1_subclass == SCLASS_MV2GPR);

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            exception    <= 1'b0;
            gpr_wen      <= 1'b0;
        end else begin
            result_valid <= s1_valid;
            exception    <= s1_exc;
            gpr_wen      <= gpr_wen_nxt;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_valid) begin
            gpr_rd    <= s1_rd;
            gpr_wdata <= ex_result;
        end
    end

endmodule

/* verification/cop_tb_vectors.svh */
// Directed coprocessor vectors covering moves, packed arithmetic, shifts and exceptions
// Row columns: instr, gpr_rs1_data, exception, gpr_wen, gpr_wdata
// write_cpr(cpr, value) and read_cpr(cpr, rd, value) expand to mv2cop and mv2gpr rows

task automatic fill_vector_table();
    // CPRs read as zero after reset
    read_cpr(5'd3, 5'd5, 32'h0000_0000);
    read_cpr(5'd15, 5'd17, 32'h0000_0000);
    write_cpr(5'd1, 32'h1234_5678);
    read_cpr(5'd1, 5'd20, 32'h1234_5678);  // Needs write-through
    write_cpr(5'd4, 32'hFFFF_FFFF);
    write_cpr(5'd5, 32'h0101_0101);

    // All ones plus 0x01 per byte
    packed_then_read(SCLASS_ADD_PX, PW_32, 5'd4, 5'd5, 32'h0101_0100);
    packed_then_read(SCLASS_ADD_PX, PW_16, 5'd4, 5'd5, 32'h0100_0100);
    packed_then_read(SCLASS_ADD_PX, PW_8, 5'd4, 5'd5, 32'h0000_0000);
    packed_then_read(SCLASS_ADD_PX, PW_4, 5'd4, 5'd5, 32'hF0F0_F0F0);
    packed_then_read(SCLASS_ADD_PX, PW_2, 5'd4, 5'd5, 32'hFCFC_FCFC);

    // Zero minus 0x01 per byte, c0 is never written
    packed_then_read(SCLASS_SUB_PX, PW_32, 5'd0, 5'd5, 32'hFEFE_FEFF);
    packed_then_read(SCLASS_SUB_PX, PW_16, 5'd0, 5'd5, 32'hFEFF_FEFF);
    packed_then_read(SCLASS_SUB_PX, PW_8, 5'd0, 5'd5, 32'hFFFF_FFFF);
    packed_then_read(SCLASS_SUB_PX, PW_4, 5'd0, 5'd5, 32'h0F0F_0F0F);
    packed_then_read(SCLASS_SUB_PX, PW_2, 5'd0, 5'd5, 32'h0303_0303);

    // Register amount 13 in c8, immediates sit in the rs2 field
    write_cpr(5'd8, 32'h0000_000D);
    packed_then_read(SCLASS_SLL_PX, PW_32, 5'd1, 5'd8, 32'h8ACF_0000);
    packed_then_read(SCLASS_ROT_PX, PW_32, 5'd1, 5'd8, 32'hB3C0_91A2);
    packed_then_read(SCLASS_SRLI_PX, PW_32, 5'd1, 5'd8, 32'h0012_3456);
    packed_then_read(SCLASS_SRL_PX, PW_8, 5'd1, 5'd8, 32'h0001_0203);    // 13 mod 8
    packed_then_read(SCLASS_SLLI_PX, PW_8, 5'd1, 5'd11, 32'h90A0_B0C0);  // 11 mod 8
    packed_then_read(SCLASS_ROTI_PX, PW_8, 5'd1, 5'd4, 32'h2143_6587);
    packed_then_read(SCLASS_ROT_PX, PW_4, 5'd1, 5'd8, 32'h8192_A3B4);    // 13 mod 4
    packed_then_read(SCLASS_SLL_PX, PW_4, 5'd1, 5'd8, 32'h2468_ACE0);
    packed_then_read(SCLASS_SRLI_PX, PW_4, 5'd1, 5'd6, 32'h0001_1112);   // 6 mod 4

    // Conditional moves, c0 is zero and c9 is not
    write_cpr(5'd9, 32'hCAFE_0001);
    add_row(move_instr(SCLASS_CMOV, 5'd9, 5'd0, 5'd10), '0, 1'b0, 1'b0, '0);
    read_cpr(5'd10, 5'd21, 32'h0000_0000);
    add_row(move_instr(SCLASS_CMOVN, 5'd9, 5'd0, 5'd10), '0, 1'b0, 1'b0, '0);
    read_cpr(5'd10, 5'd22, 32'hCAFE_0001);
    add_row(move_instr(SCLASS_CMOV, 5'd1, 5'd9, 5'd11), '0, 1'b0, 1'b0, '0);
    read_cpr(5'd11, 5'd23, 32'h1234_5678);
    add_row(move_instr(SCLASS_CMOVN, 5'd4, 5'd9, 5'd11), '0, 1'b0, 1'b0, '0);
    read_cpr(5'd11, 5'd24, 32'h1234_5678);

    // Illegal instructions aimed at c12 must leave it alone
    write_cpr(5'd12, 32'h5A5A_A5A5);
    add_row(packed_instr(SCLASS_ADD_PX, PW_32, 5'd4, 5'd5, 5'd12) ^ 32'h1, '0, 1'b1, 1'b0, '0);
    add_row(move_instr(SCLASS_MV2GPR, 5'd12, 5'd0, 5'd26) ^ 32'h1, '0, 1'b1, 1'b0, '0);
    add_row(encode_instr(3'd0, SCLASS_ADD_PX, PW_32, 5'd4, 5'd5, 5'd12), '0, 1'b1, 1'b0, '0);
    add_row(encode_instr(ICLASS_TWIDDLE, 4'd0, PW_32, 5'd4, 5'd5, 5'd12), '0, 1'b1, 1'b0, '0);
    add_row(packed_instr(SCLASS_ADD_PX, 3'd5, 5'd4, 5'd5, 5'd12), '0, 1'b1, 1'b0, '0);
    add_row(packed_instr(4'd2, PW_32, 5'd4, 5'd5, 5'd12), '0, 1'b1, 1'b0, '0);  // Multiply slot
    add_row(move_instr(4'd4, 5'd4, 5'd0, 5'd12), '0, 1'b1, 1'b0, '0);
    read_cpr(5'd12, 5'd25, 32'h5A5A_A5A5);
endtask

/* verification/cop_tb.sv */
// Coprocessor testbench running a directed vector table and a random packed-add phase
`timescale 1ns/1ns
`include "cop_defines.svh"

module cop_tb;

    import cop_pkg::*;

    typedef struct packed {
        word_t instr;
        word_t gpr;     // gpr_rs1_data presented with the strobe
        logic  exc;
        logic  wen;
        word_t wdata;   // Compared only when wen is expected
    } vec_t;

    // Two cycles from the sampling edge and half a cycle to the falling edge
    localparam time RESULT_DELAY = 25;

    logic     g_clk;
    logic     rst_n;
    logic     instr_valid;
    word_t    instr;
    word_t    gpr_rs1_data;
    logic     result_valid;
    logic     exception;
    logic     gpr_wen;
    gpr_idx_t gpr_rd;
    word_t    gpr_wdata;

    vec_t     table_q[$];
    vec_t     exp_q[$];     // Instructions in flight
    time      issue_q[$];
    vec_t     exp_row;
    time      issued;
    int       errors;
    int       checks;
    int       seed;
    int       wait_cycles;
    logic     timed_out;

    cop_top cop_top_i (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .gpr_rs1_data (gpr_rs1_data),
        .result_valid (result_valid),
        .exception    (exception),
        .gpr_wen      (gpr_wen),
        .gpr_rd       (gpr_rd),
        .gpr_wdata    (gpr_wdata)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    function automatic word_t encode_instr(iclass_t cls, subclass_t sub, pw_t pw,
                                           logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd);
        return {cls, sub, rs2, rs1, pw, rd, `COP_OPCODE};
    endfunction

    function automatic word_t move_instr(subclass_t sub, logic [4:0] rs1, logic [4:0] rs2,
                                         logic [4:0] rd);
        return encode_instr(ICLASS_MOVE, sub, PW_32, rs1, rs2, rd);
    endfunction

    function automatic word_t packed_instr(subclass_t sub, pw_t pw, logic [4:0] rs1,
                                           logic [4:0] rs2, logic [4:0] rd);
        return encode_instr(ICLASS_PACKED_ARITH, sub, pw, rs1, rs2, rd);
    endfunction

    // Lane-wise sum where each lane wraps on its own
    function automatic word_t lane_add(word_t a, word_t b, int lw);
        word_t mask;
        word_t r;
        mask = (lw >= 32) ? '1 : ((32'd1 << lw) - 32'd1);
        r = '0;
        for (int i = 0; i < 32; i += lw) begin
            r = r | ((((a >> i) + (b >> i)) & mask) << i);
        end
        return r;
    endfunction

    task automatic add_row(input word_t ins, input word_t gpr, input logic exc,
                           input logic wen, input word_t wdata);
        table_q.push_back({ins, gpr, exc, wen, wdata});
    endtask

    task automatic write_cpr(input logic [4:0] cr, input word_t value);
        add_row(move_instr(SCLASS_MV2COP, 5'd0, 5'd0, cr), value, 1'b0, 1'b0, '0);
    endtask

    task automatic read_cpr(input logic [4:0] cr, input logic [4:0] rd, input word_t value);
        add_row(move_instr(SCLASS_MV2GPR, cr, 5'd0, rd), '0, 1'b0, 1'b1, value);
    endtask

    // Packed op into c6 and a read back right behind it
    task automatic packed_then_read(input subclass_t sub, input pw_t pw, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input word_t value);
        add_row(packed_instr(sub, pw, rs1, rs2, 5'd6), '0, 1'b0, 1'b0, '0);
        read_cpr(5'd6, 5'd18, value);
    endtask

    task automatic add_random_rows();
        word_t a;
        word_t b;
        pw_t   pw;
        int    lw;
        for (int k = 0; k < 16; k++) begin
            a  = $random(seed);
            b  = $random(seed);
            pw = (k % 2 == 0) ? PW_8 : PW_16;
            lw = (k % 2 == 0) ? 8 : 16;
            write_cpr(5'd13, a);
            write_cpr(5'd14, b);
            packed_then_read(SCLASS_ADD_PX, pw, 5'd13, 5'd14, lane_add(a, b, lw));
        end
    endtask

    `include "cop_tb_vectors.svh"

    // Sampled on the falling edge clear of the DUT register updates
    always @(negedge g_clk) begin
        if (rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result pulse at %0t with no instruction outstanding", $time);
            end else begin
                exp_row = exp_q.pop_front();
                issued  = issue_q.pop_front();
                checks++;
                assert ($time - issued == RESULT_DELAY) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: instr %h result came %0t after strobe",
                             $time, exp_row.instr, $time - issued);
                end
                assert (exception === exp_row.exc && gpr_wen === exp_row.wen) else begin
                    errors++;
                    $display("CHECK FAILED at %0t: instr %h exception %b gpr_wen %b, exp %b %b",
                             $time, exp_row.instr, exception, gpr_wen, exp_row.exc, exp_row.wen);
                end
                if (exp_row.wen) begin
                    assert (gpr_rd === exp_row.instr[11:7] &&
                            gpr_wdata === exp_row.wdata) else begin
                        errors++;
                        $display("CHECK FAILED at %0t: instr %h gave rd %0d data %h, exp %0d %h",
                                 $time, exp_row.instr, gpr_rd, gpr_wdata,
                                 exp_row.instr[11:7], exp_row.wdata);
                    end
                end
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        gpr_rs1_data = '0;
        errors       = 0;
        checks       = 0;
        timed_out    = 1'b0;
        seed         = 30254;
        fill_vector_table();
        add_random_rows();
        repeat (8) @(posedge g_clk);
        rst_n <= 1'b1;
        @(posedge g_clk);
        // One instruction per cycle
        foreach (table_q[i]) begin
            @(posedge g_clk);
            instr_valid  <= 1'b1;
            instr        <= table_q[i].instr;
            gpr_rs1_data <= table_q[i].gpr;
            exp_q.push_back(table_q[i]);
            issue_q.push_back($time);
        end
        @(posedge g_clk);
        instr_valid <= 1'b0;
        wait_cycles = 0;
        while (exp_q.size() != 0 && wait_cycles < 10) begin
            @(posedge g_clk);
            wait_cycles++;
        end
        if (exp_q.size() != 0) begin
            timed_out = 1'b1;
            $display("Timeout: %0d results never arrived", exp_q.size());
        end
        // Any pulse in the idle tail has no instruction behind it
        repeat (4) @(posedge g_clk);
        $display("Results checked: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
+incdir+verification
verilog/cop_pkg.sv
verilog/cop_idecode.sv
verilog/cop_regfile.sv
verilog/cop_palu.sv
verilog/cop_top.sv
verification/cop_tb.sv

/* Bender.yml */
package:
  name: cop

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cop_pkg.sv
      - verilog/cop_idecode.sv
      - verilog/cop_regfile.sv
      - verilog/cop_palu.sv
      - verilog/cop_top.sv

  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/cop_tb.sv
